// File: hw/ahb_mem_cfg.svh
`ifndef AHB_MEM_CFG_SVH
`define AHB_MEM_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// memory geometry
////////////////////////////////////////////////////////////////////////////

// storage depth in bytes
`define MEM_BYTES       256

// byte address width inside the memory
`define MEM_AW          8

// bus word
`define BUS_W           32
`define BUS_BYTES       4

////////////////////////////////////////////////////////////////////////////
// response codes and burst limits
////////////////////////////////////////////////////////////////////////////

// hresp encodings
`define HRESP_OKAY      2'b00
`define HRESP_ERROR     2'b01

// largest wrap block is sixteen word beats
`define MAX_WRAP_BYTES  64

`endif

// File: hw/ahb_mem_pkg.sv
`include "ahb_mem_cfg.svh"

package ahb_mem_pkg;

    // one bus word seen whole or lane by lane
    typedef union packed
    {
        logic [`BUS_W-1:0]          word;
        logic [`BUS_BYTES-1:0][7:0] lanes;
    } bus_word_u;

    // transfer type on htrans
    typedef enum logic [1:0]
    {
        NONSEQ = 2'd0,
        SEQ    = 2'd1,
        BUSY   = 2'd2,
        IDLE   = 2'd3
    } htrans_e;

    // burst type on hburst
    typedef enum logic [2:0]
    {
        SINGLE = 3'd0,
        INCR   = 3'd1,
        WRAP4  = 3'd2,
        INCR4  = 3'd3,
        WRAP8  = 3'd4,
        INCR8  = 3'd5,
        WRAP16 = 3'd6,
        INCR16 = 3'd7
    } hburst_e;

    // codes above WORD are not supported
    typedef enum logic [2:0]
    {
        BYTE = 3'd0,
        HALF = 3'd1,
        WORD = 3'd2
    } hsize_e;

endpackage

// File: hw/ahb_beat_capture.sv
`include "ahb_mem_cfg.svh"

module ahb_beat_capture
(
    input  logic                   clk,
    input  logic                   hresetn,
    input  logic                   hsel,
    input  logic                   hwrite,
    input  logic [1:0]             htrans,
    input  logic [2:0]             hburst,
    input  logic [2:0]             hsize,
    input  logic [`BUS_W-1:0]      haddr,
    input  logic [`BUS_W-1:0]      hwdata,
    input  logic [`MEM_AW:0]       next_addr,
    output logic                   beat_valid,
    output logic                   beat_err,
    output logic                   beat_write,
    output logic [`MEM_AW:0]       beat_addr,
    output logic [2:0]             beat_size,
    output logic [2:0]             beat_burst,
    output ahb_mem_pkg::bus_word_u beat_data
);

    // parking address for a NONSEQ far outside memory
    localparam logic [`MEM_AW:0] OUT_ADDR = `MEM_BYTES;

    logic                accept;
    logic                is_seq;
    logic                is_wrap;
    logic                size_ok;
    logic                range_err;
    logic                in_burst;
    logic [`MEM_AW:0]    start_addr;
    logic [3:0]          size_bytes;
    logic [`MEM_AW+1:0]  last_byte;

    ////////////////////////////////////////////////////////////////////////////
    // beat qualification and range check
    ////////////////////////////////////////////////////////////////////////////

    assign is_seq = htrans == ahb_mem_pkg::SEQ;
    assign accept = hsel && (is_seq || htrans == ahb_mem_pkg::NONSEQ);

    assign is_wrap = hburst == ahb_mem_pkg::WRAP4
                  || hburst == ahb_mem_pkg::WRAP8
                  || hburst == ahb_mem_pkg::WRAP16;

    assign size_ok    = hsize <= ahb_mem_pkg::WORD;
    assign size_bytes = size_ok ? 4'd1 << hsize : 4'd4;

    // SEQ continues from the previous beat
    always_comb
    begin
        if (is_seq)
            start_addr = next_addr;
        else if (haddr >= `MEM_BYTES)
            start_addr = OUT_ADDR;
        else
            start_addr = haddr[`MEM_AW:0];
    end

    // extra top bit keeps the sum from wrapping
    assign last_byte = {1'b0, start_addr} + size_bytes - 1'b1;

    // wrap blocks are aligned so only the start needs checking
    always_comb
    begin
        range_err = start_addr >= `MEM_BYTES;
        if (!is_wrap && last_byte >= `MEM_BYTES)
            range_err = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            beat_valid <= 1'b0;
            beat_err   <= 1'b0;
            in_burst   <= 1'b0;
        end
        else
        begin
            beat_valid <= accept;
            beat_err   <= accept && (!size_ok || range_err);
            if (accept && !is_seq)
                in_burst <= hburst != ahb_mem_pkg::SINGLE;
            else if (hsel && htrans == ahb_mem_pkg::IDLE)
                in_burst <= 1'b0;
        end
    end

    // payload only moves on an accepted beat
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            beat_write     <= hwrite;
            beat_addr      <= start_addr;
            beat_size      <= hsize;
            beat_burst     <= hburst;
            beat_data.word <= hwdata;
        end
    end

    // a SEQ beat must follow a NONSEQ that opened a burst
    assert property (@(posedge clk) disable iff (!hresetn)
        (hsel && is_seq) |-> in_burst)
    else
        $error("SEQ beat without an open burst");

endmodule

// File: hw/burst_addr_gen.sv
`include "ahb_mem_cfg.svh"

module burst_addr_gen
(
    input  logic             clk,
    input  logic             hresetn,
    input  logic             beat_valid,
    input  logic [`MEM_AW:0] beat_addr,
    input  logic [2:0]       beat_size,
    input  logic [2:0]       beat_burst,
    output logic [`MEM_AW:0] byte_addr0,
    output logic [`MEM_AW:0] byte_addr1,
    output logic [`MEM_AW:0] byte_addr2,
    output logic [`MEM_AW:0] byte_addr3,
    output logic [`MEM_AW:0] next_addr
);

    localparam int WRAP_LG = $clog2(`MAX_WRAP_BYTES);

    logic               is_wrap;
    logic [2:0]         size_lg;
    logic [2:0]         beats_lg;
    logic [3:0]         size_bytes;
    logic [WRAP_LG:0]   blk_bytes;
    logic [`MEM_AW:0]   wrap_mask;
    logic [`MEM_AW:0]   next_comb;
    logic [`MEM_AW:0]   next_hold;

    // bits under the mask wrap while the rest stay fixed
    function automatic logic [`MEM_AW:0] wrap_step
    (
        input logic [`MEM_AW:0] base,
        input logic [3:0]       delta,
        input logic [`MEM_AW:0] mask
    );
        return (base & ~mask) | ((base + delta) & mask);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // wrap block size
    ////////////////////////////////////////////////////////////////////////////

    // illegal sizes are error beats and only need a defined value
    assign size_lg    = (beat_size > ahb_mem_pkg::WORD) ? 3'd2 : beat_size;
    assign size_bytes = 4'd1 << size_lg;

    always_comb
    begin
        is_wrap  = 1'b1;
        beats_lg = 3'd0;
        case (beat_burst)
            ahb_mem_pkg::WRAP4:  beats_lg = 3'd2;
            ahb_mem_pkg::WRAP8:  beats_lg = 3'd3;
            ahb_mem_pkg::WRAP16: beats_lg = 3'd4;
            default:             is_wrap  = 1'b0;
        endcase
    end

    // beats times size
    assign blk_bytes = (WRAP_LG+1)'(1) << (beats_lg + size_lg);

    // an all-ones mask turns the step into a plain increment
    assign wrap_mask = is_wrap ? (`MEM_AW+1)'(blk_bytes - 1'b1) : '1;

    ////////////////////////////////////////////////////////////////////////////
    // byte and next beat addresses
    ////////////////////////////////////////////////////////////////////////////

    assign byte_addr0 = wrap_step(beat_addr, 4'd0, wrap_mask);
    assign byte_addr1 = wrap_step(beat_addr, 4'd1, wrap_mask);
    assign byte_addr2 = wrap_step(beat_addr, 4'd2, wrap_mask);
    assign byte_addr3 = wrap_step(beat_addr, 4'd3, wrap_mask);
    assign next_comb  = wrap_step(beat_addr, size_bytes, wrap_mask);

    always_ff @(posedge clk)
    begin
        if (!hresetn)
            next_hold <= '0;
        else if (beat_valid)
            next_hold <= next_comb;
    end

    // back to back SEQ beat takes the fresh value
    assign next_addr = beat_valid ? next_comb : next_hold;

    // wrap bursts have to start inside memory
    assert property (@(posedge clk) disable iff (!hresetn)
        (beat_valid && is_wrap) |-> beat_addr < `MEM_BYTES)
    else
        $error("wrap burst starts outside memory");

endmodule

// File: hw/byte_mem.sv
`include "ahb_mem_cfg.svh"

module byte_mem
(
    input  logic                   clk,
    input  logic                   hresetn,
    input  logic                   beat_valid,
    input  logic                   beat_err,
    input  logic                   beat_write,
    input  logic [2:0]             beat_size,
    input  ahb_mem_pkg::bus_word_u beat_data,
    input  logic [`MEM_AW:0]       byte_addr0,
    input  logic [`MEM_AW:0]       byte_addr1,
    input  logic [`MEM_AW:0]       byte_addr2,
    input  logic [`MEM_AW:0]       byte_addr3,
    output ahb_mem_pkg::bus_word_u rd_word
);

    logic [7:0]             mem [`MEM_BYTES];
    logic [`MEM_AW:0]       lane_addr [`BUS_BYTES];
    logic [`BUS_BYTES-1:0]  lane_en;
    logic                   wr_en;
    logic                   rd_en;

    assign lane_addr[0] = byte_addr0;
    assign lane_addr[1] = byte_addr1;
    assign lane_addr[2] = byte_addr2;
    assign lane_addr[3] = byte_addr3;

    // lanes from 0 upward
    always_comb
    begin
        case (beat_size)
            ahb_mem_pkg::BYTE: lane_en = 4'b0001;
            ahb_mem_pkg::HALF: lane_en = 4'b0011;
            default:           lane_en = 4'b1111;
        endcase
    end

    assign wr_en = hresetn && beat_valid && !beat_err && beat_write;
    assign rd_en = hresetn && beat_valid && !beat_err && !beat_write;

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `BUS_BYTES; i++)
        begin
            if (wr_en && lane_en[i])
                mem[lane_addr[i][`MEM_AW-1:0]] <= beat_data.lanes[i];
        end
    end

    // unused upper lanes read as zero
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            for (int i = 0; i < `BUS_BYTES; i++)
            begin
                if (lane_en[i])
                    rd_word.lanes[i] <= mem[lane_addr[i][`MEM_AW-1:0]];
                else
                    rd_word.lanes[i] <= 8'h00;
            end
        end
    end

    // capture range check and address arithmetic keep written lanes in memory
    for (genvar g = 0; g < `BUS_BYTES; g++)
    begin : g_lane_chk
        assert property (@(posedge clk) disable iff (!hresetn)
            (wr_en && lane_en[g]) |-> lane_addr[g] < `MEM_BYTES)
        else
            $error("write lane %0d outside memory", g);
    end

endmodule

// File: hw/ahb_resp_gen.sv
`include "ahb_mem_cfg.svh"

module ahb_resp_gen
(
    input  logic                   clk,
    input  logic                   hresetn,
    input  logic                   beat_valid,
    input  logic                   beat_err,
    input  logic                   beat_write,
    input  ahb_mem_pkg::bus_word_u rd_word,
    output logic                   hready,
    output logic [1:0]             hresp,
    output logic [`BUS_W-1:0]      hrdata
);

    logic valid_q;
    logic err_q;
    logic write_q;

    // status stage in step with the memory access
    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end
        else
        begin
            valid_q <= beat_valid;
            err_q   <= beat_err;
        end
    end

    always_ff @(posedge clk)
    begin
        write_q <= beat_write;
    end

    ////////////////////////////////////////////////////////////////////////////
    // response stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            hready <= 1'b0;
            hresp  <= `HRESP_OKAY;
            hrdata <= '0;
        end
        else
        begin
            hready <= valid_q;
            hresp  <= err_q ? `HRESP_ERROR : `HRESP_OKAY;
            // data only on a good read
            if (valid_q && !err_q && !write_q)
                hrdata <= rd_word.word;
            else
                hrdata <= '0;
        end
    end

    // ERROR never shows without the ready strobe
    assert property (@(posedge clk) disable iff (!hresetn)
        (hresp == `HRESP_ERROR) |-> hready)
    else
        $error("ERROR response while hready is low");

endmodule

// File: hw/ahb_mem_slave.sv
`include "ahb_mem_cfg.svh"

module ahb_mem_slave
(
    input  logic              clk,
    input  logic              hresetn,
    input  logic              hsel,
    input  logic              hwrite,
    input  logic [1:0]        htrans,
    input  logic [2:0]        hburst,
    input  logic [2:0]        hsize,
    input  logic [`BUS_W-1:0] haddr,
    input  logic [`BUS_W-1:0] hwdata,
    output logic              hready,
    output logic [1:0]        hresp,
    output logic [`BUS_W-1:0] hrdata
);

    // registered beat
    logic                   beat_valid;
    logic                   beat_err;
    logic                   beat_write;
    logic [`MEM_AW:0]       beat_addr;
    logic [2:0]             beat_size;
    logic [2:0]             beat_burst;
    ahb_mem_pkg::bus_word_u beat_data;

    // address generator results
    logic [`MEM_AW:0]       byte_addr0;
    logic [`MEM_AW:0]       byte_addr1;
    logic [`MEM_AW:0]       byte_addr2;
    logic [`MEM_AW:0]       byte_addr3;
    logic [`MEM_AW:0]       next_addr;

    ahb_mem_pkg::bus_word_u rd_word;

    ahb_beat_capture i_capture
    (
        .clk        (clk),
        .hresetn    (hresetn),
        .hsel       (hsel),
        .hwrite     (hwrite),
        .htrans     (htrans),
        .hburst     (hburst),
        .hsize      (hsize),
        .haddr      (haddr),
        .hwdata     (hwdata),
        .next_addr  (next_addr),
        .beat_valid (beat_valid),
        .beat_err   (beat_err),
        .beat_write (beat_write),
        .beat_addr  (beat_addr),
        .beat_size  (beat_size),
        .beat_burst (beat_burst),
        .beat_data  (beat_data)
    );

    burst_addr_gen i_addr_gen
    (
        .clk        (clk),
        .hresetn    (hresetn),
        .beat_valid (beat_valid),
        .beat_addr  (beat_addr),
        .beat_size  (beat_size),
        .beat_burst (beat_burst),
        .byte_addr0 (byte_addr0),
        .byte_addr1 (byte_addr1),
        .byte_addr2 (byte_addr2),
        .byte_addr3 (byte_addr3),
        .next_addr  (next_addr)
    );

    byte_mem i_mem
    (
        .clk        (clk),
        .hresetn    (hresetn),
        .beat_valid (beat_valid),
        .beat_err   (beat_err),
        .beat_write (beat_write),
        .beat_size  (beat_size),
        .beat_data  (beat_data),
        .byte_addr0 (byte_addr0),
        .byte_addr1 (byte_addr1),
        .byte_addr2 (byte_addr2),
        .byte_addr3 (byte_addr3),
        .rd_word    (rd_word)
    );

    ahb_resp_gen i_resp
    (
        .clk        (clk),
        .hresetn    (hresetn),
        .beat_valid (beat_valid),
        .beat_err   (beat_err),
        .beat_write (beat_write),
        .rd_word    (rd_word),
        .hready     (hready),
        .hresp      (hresp),
        .hrdata     (hrdata)
    );

endmodule

// File: test/tb_ahb_mem.sv
`include "ahb_mem_cfg.svh"

module tb_ahb_mem;

    logic              clk;
    logic              hresetn;
    logic              hsel;
    logic              hwrite;
    logic [1:0]        htrans;
    logic [2:0]        hburst;
    logic [2:0]        hsize;
    logic [`BUS_W-1:0] haddr;
    logic [`BUS_W-1:0] hwdata;
    logic              hready;
    logic [1:0]        hresp;
    logic [`BUS_W-1:0] hrdata;

    // trace columns, one entry per beat
    string             t_name [$];
    logic              t_write [$];
    logic [1:0]        t_trans [$];
    logic [2:0]        t_burst [$];
    logic [2:0]        t_size [$];
    logic [`BUS_W-1:0] t_addr [$];
    logic [`BUS_W-1:0] t_data [$];
    logic [1:0]        t_resp [$];
    logic [`BUS_W-1:0] t_rdata [$];

    // responses still owed by the DUT
    string             exp_name [$];
    logic [1:0]        exp_resp [$];
    logic [`BUS_W-1:0] exp_rdata [$];

    int                data_errs;
    int                proto_errs;
    int                cycles;
    int                limit;
    logic [31:0]       rng;

    ahb_mem_slave i_dut
    (
        .clk     (clk),
        .hresetn (hresetn),
        .hsel    (hsel),
        .hwrite  (hwrite),
        .htrans  (htrans),
        .hburst  (hburst),
        .hsize   (hsize),
        .haddr   (haddr),
        .hwdata  (hwdata),
        .hready  (hready),
        .hresp   (hresp),
        .hrdata  (hrdata)
    );

    always #50 clk = ~clk;

    // run limit from the trace length
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit)
        begin
            $display("timeout after %0d cycles, DUT stopped answering", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // trace loading
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_trace();
        int          fd;
        int          n;
        int          bursts;
        string       line;
        string       name;
        logic [31:0] fld [8];
        bursts = 0;
        fd = $fopen("test/ahb_mem_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file");
            proto_errs++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                // skip comments and blank lines
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, fld[0], fld[1],
                            fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
                if (n != 9)
                begin
                    $display("malformed trace line: %s", line);
                    proto_errs++;
                end
                else
                begin
                    t_name.push_back(name);
                    t_write.push_back(fld[0][0]);
                    t_trans.push_back(fld[1][1:0]);
                    t_burst.push_back(fld[2][2:0]);
                    t_size.push_back(fld[3][2:0]);
                    t_addr.push_back(fld[4]);
                    t_data.push_back(fld[5]);
                    t_resp.push_back(fld[6][1:0]);
                    t_rdata.push_back(fld[7]);
                    if (fld[1][1:0] == ahb_mem_pkg::NONSEQ)
                        bursts++;
                end
            end
            $fclose(fd);
        end
        limit = t_name.size() * 4 + 3 * bursts + 40;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driving and checking
    ////////////////////////////////////////////////////////////////////////////

    // outputs are stable at the falling edge
    task automatic check_outputs();
        string             name;
        logic [1:0]        er;
        logic [`BUS_W-1:0] ed;
        if (hready)
        begin
            assert (exp_resp.size() != 0)
            else
            begin
                $display("hready pulse with no beat outstanding");
                proto_errs++;
            end
            if (exp_resp.size() != 0)
            begin
                name = exp_name.pop_front();
                er   = exp_resp.pop_front();
                ed   = exp_rdata.pop_front();
                assert (hresp === er)
                else
                begin
                    $display("ERR %s hresp expected %0h actual %0h", name, er, hresp);
                    data_errs++;
                end
                assert (hrdata === ed)
                else
                begin
                    $display("ERR %s hrdata expected %h actual %h", name, ed, hrdata);
                    data_errs++;
                end
            end
        end
        else
        begin
            assert (hresp === `HRESP_OKAY)
            else
            begin
                $display("hresp is not OKAY while hready is low");
                proto_errs++;
            end
        end
    endtask

    task automatic clock_step();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic drive_idle();
        hsel   = 1'b1;
        hwrite = 1'b0;
        htrans = ahb_mem_pkg::IDLE;
    endtask

    task automatic drive_beat(input int i);
        hsel   = 1'b1;
        hwrite = t_write[i];
        htrans = t_trans[i];
        hburst = t_burst[i];
        hsize  = t_size[i];
        haddr  = t_addr[i];
        hwdata = t_data[i];
        exp_name.push_back(t_name[i]);
        exp_resp.push_back(t_resp[i]);
        exp_rdata.push_back(t_rdata[i]);
    endtask

    initial
    begin
        int gap;
        int drain;
        clk        = 1'b0;
        hresetn    = 1'b0;
        hsel       = 1'b0;
        hwrite     = 1'b0;
        htrans     = ahb_mem_pkg::IDLE;
        hburst     = ahb_mem_pkg::SINGLE;
        hsize      = ahb_mem_pkg::BYTE;
        haddr      = '0;
        hwdata     = '0;
        data_errs  = 0;
        proto_errs = 0;
        cycles     = 0;
        limit      = 0;
        rng        = 32'h669aa82c;
        load_trace();

        repeat (10) @(negedge clk);
        hresetn = 1'b1;

        for (int i = 0; i < t_name.size(); i++)
        begin
            // idle gap only ahead of a new burst
            if (t_trans[i] == ahb_mem_pkg::NONSEQ)
            begin
                rng = xorshift(rng);
                gap = int'(rng[1:0]);
                repeat (gap)
                begin
                    clock_step();
                    drive_idle();
                end
            end
            clock_step();
            drive_beat(i);
        end
        clock_step();
        drive_idle();

        // let the pipeline empty, plus a little to catch stray pulses
        drain = 0;
        while (exp_resp.size() != 0 && drain < 8)
        begin
            clock_step();
            drain++;
        end
        repeat (2) clock_step();
        assert (exp_resp.size() == 0)
        else
        begin
            $display("%0d beats never got an hready pulse", exp_resp.size());
            proto_errs++;
        end

        $display("data errors: %0d, protocol errors: %0d", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: test/ahb_mem_trace.txt
# name hwrite htrans hburst hsize haddr hwdata exp_hresp exp_hrdata
# fields after the name are hex; htrans 0 NONSEQ 1 SEQ, hburst and hsize use the bus codes
single_wr 1 0 0 0 10 ffffffa5 0 00000000
single_wr 1 0 0 1 12 1111beef 0 00000000
single_wr 1 0 0 2 14 12345678 0 00000000
single_rd 0 0 0 0 10 00000000 0 000000a5
single_rd 0 0 0 1 12 00000000 0 0000beef
single_rd 0 0 0 2 14 00000000 0 12345678
single_rd 0 0 0 0 13 00000000 0 000000be
single_rd 0 0 0 1 15 00000000 0 00003456
incr4_wr 1 0 3 0 20 eeeeeec0 0 00000000
incr4_wr 1 1 3 0 21 eeeeeec1 0 00000000
incr4_wr 1 1 3 0 22 eeeeeec2 0 00000000
incr4_wr 1 1 3 0 23 eeeeeec3 0 00000000
incr8_wr 1 0 5 1 24 7777d1d0 0 00000000
incr8_wr 1 1 5 1 26 7777d3d2 0 00000000
incr8_wr 1 1 5 1 28 7777d5d4 0 00000000
incr8_wr 1 1 5 1 2a 7777d7d6 0 00000000
incr8_wr 1 1 5 1 2c 7777d9d8 0 00000000
incr8_wr 1 1 5 1 2e 7777dbda 0 00000000
incr8_wr 1 1 5 1 30 7777dddc 0 00000000
incr8_wr 1 1 5 1 32 7777dfde 0 00000000
incr16_wr 1 0 7 2 40 43424140 0 00000000
incr16_wr 1 1 7 2 44 47464544 0 00000000
incr16_wr 1 1 7 2 48 4b4a4948 0 00000000
incr16_wr 1 1 7 2 4c 4f4e4d4c 0 00000000
incr16_wr 1 1 7 2 50 53525150 0 00000000
incr16_wr 1 1 7 2 54 57565554 0 00000000
incr16_wr 1 1 7 2 58 5b5a5958 0 00000000
incr16_wr 1 1 7 2 5c 5f5e5d5c 0 00000000
incr16_wr 1 1 7 2 60 63626160 0 00000000
incr16_wr 1 1 7 2 64 67666564 0 00000000
incr16_wr 1 1 7 2 68 6b6a6968 0 00000000
incr16_wr 1 1 7 2 6c 6f6e6d6c 0 00000000
incr16_wr 1 1 7 2 70 73727170 0 00000000
incr16_wr 1 1 7 2 74 77767574 0 00000000
incr16_wr 1 1 7 2 78 7b7a7978 0 00000000
incr16_wr 1 1 7 2 7c 7f7e7d7c 0 00000000
incr_rd 0 0 3 2 20 00000000 0 c3c2c1c0
incr_rd 0 1 3 2 24 00000000 0 d3d2d1d0
incr_rd 0 1 3 2 28 00000000 0 d7d6d5d4
incr_rd 0 1 3 2 2c 00000000 0 dbdad9d8
incr_rd 0 0 0 1 30 00000000 0 0000dddc
incr_rd 0 0 0 2 7c 00000000 0 7f7e7d7c
wrap4_wr 1 0 2 0 86 55555586 0 00000000
wrap4_wr 1 1 2 0 87 55555587 0 00000000
wrap4_wr 1 1 2 0 84 55555584 0 00000000
wrap4_wr 1 1 2 0 85 55555585 0 00000000
wrap4_rd 0 0 0 0 84 00000000 0 00000084
wrap8_wr 1 0 4 1 9c 33339d9c 0 00000000
wrap8_wr 1 1 4 1 9e 33339f9e 0 00000000
wrap8_wr 1 1 4 1 90 33339190 0 00000000
wrap8_wr 1 1 4 1 92 33339392 0 00000000
wrap8_wr 1 1 4 1 94 33339594 0 00000000
wrap8_wr 1 1 4 1 96 33339796 0 00000000
wrap8_wr 1 1 4 1 98 33339998 0 00000000
wrap8_wr 1 1 4 1 9a 33339b9a 0 00000000
wrap8_rd 0 0 0 1 90 00000000 0 00009190
wrap16_wr 1 0 6 2 f0 f3f2f1f0 0 00000000
wrap16_wr 1 1 6 2 f4 f7f6f5f4 0 00000000
wrap16_wr 1 1 6 2 f8 fbfaf9f8 0 00000000
wrap16_wr 1 1 6 2 fc fffefdfc 0 00000000
wrap16_wr 1 1 6 2 c0 c3c2c1c0 0 00000000
wrap16_wr 1 1 6 2 c4 c7c6c5c4 0 00000000
wrap16_wr 1 1 6 2 c8 cbcac9c8 0 00000000
wrap16_wr 1 1 6 2 cc cfcecdcc 0 00000000
wrap16_wr 1 1 6 2 d0 d3d2d1d0 0 00000000
wrap16_wr 1 1 6 2 d4 d7d6d5d4 0 00000000
wrap16_wr 1 1 6 2 d8 dbdad9d8 0 00000000
wrap16_wr 1 1 6 2 dc dfdedddc 0 00000000
wrap16_wr 1 1 6 2 e0 e3e2e1e0 0 00000000
wrap16_wr 1 1 6 2 e4 e7e6e5e4 0 00000000
wrap16_wr 1 1 6 2 e8 ebeae9e8 0 00000000
wrap16_wr 1 1 6 2 ec efeeedec 0 00000000
wrap16_rd 0 0 0 2 c0 00000000 0 c3c2c1c0
err_range 1 0 0 2 fe 01020304 1 00000000
err_size 1 0 0 3 10 000000ee 1 00000000
err_addr 0 0 0 2 100 00000000 1 00000000
err_cross 0 0 3 1 fc 00000000 0 0000fdfc
err_cross 0 1 3 1 fe 00000000 0 0000fffe
err_cross 0 1 3 1 100 00000000 1 00000000
err_cross 0 1 3 1 102 00000000 1 00000000
err_check 0 0 0 0 10 00000000 0 000000a5

// File: filelist.f
+incdir+hw
hw/ahb_mem_pkg.sv
hw/ahb_beat_capture.sv
hw/burst_addr_gen.sv
hw/byte_mem.sv
hw/ahb_resp_gen.sv
hw/ahb_mem_slave.sv
test/tb_ahb_mem.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ahb_mem
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# the run passes only when the testbench prints the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
